// File: hdl/llfifo_geom_pkg.sv
`default_nettype none

package llfifo_geom_pkg;

  // --------------------
  // data path
  // --------------------
  localparam int width = 8;  // bits per data word

  // --------------------
  // paging
  // --------------------
  localparam int pagesize  = 8;   // words per page
  localparam int num_pages = 16;  // pages in the shared data memory

  // --------------------
  // queues
  // --------------------
  localparam int num_queues = 4;

  // derived widths
  localparam int qid_sz  = 2;  // log2(num_queues)
  localparam int pid_sz  = 4;  // log2(num_pages)
  localparam int wp_sz   = 3;  // log2(pagesize)
  localparam int mm_sz   = 7;  // page id + word pointer
  localparam int fcnt_sz = 5;  // holds 0..num_pages

endpackage

`default_nettype wire

// File: hdl/llfifo_ctl_pkg.sv
`default_nettype none

package llfifo_ctl_pkg;

  // link memory sequencer
  typedef enum logic [1:0] {
    pp_idle    = 2'd0,  // normal operation
    pp_init    = 2'd1,  // building the free list
    pp_adv_ptr = 2'd2   // free head waits for its link
  } pp_state_t;

  // one queue descriptor, head or tail side
  typedef struct packed {
    logic                                valid;
    logic [llfifo_geom_pkg::pid_sz-1:0]  page;
    logic [llfifo_geom_pkg::wp_sz-1:0]   wp;
  } desc_t;

  // --------------------
  // output buffer
  // --------------------
  localparam int ob_depth  = 4;
  localparam int ob_cnt_sz = 3;  // counts 0..ob_depth+1

endpackage

`default_nettype wire

// File: hdl/llfifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

module llfifo_ram #(
  parameter int dw    = 8,
  parameter int depth = 16
) (
  input  wire logic                     clk,
  input  wire logic                     wr_en,
  input  wire logic [$clog2(depth)-1:0] wr_addr,
  input  wire logic [dw-1:0]            wr_data,
  input  wire logic                     rd_en,
  input  wire logic [$clog2(depth)-1:0] rd_addr,
  output logic      [dw-1:0]            rd_data
);

  logic [dw-1:0] mem [depth];

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      rd_data <= mem[rd_addr];
    end
  end

  a_rd_addr_range : assert property (
    @(posedge clk) rd_en |-> (int'(rd_addr) < depth)
  );

endmodule

`default_nettype wire

// File: hdl/llfifo_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module llfifo_ctl (
  input  wire logic                                    clk,
  input  wire logic                                    reset,
  input  wire logic                                    init,
  output logic                                         init_done,
  input  wire logic                                    c_srdy,
  output logic                                         c_drdy,
  input  wire logic [llfifo_geom_pkg::qid_sz-1:0]      c_qid,
  output logic                                         mm_wr_en,
  output logic                                         mm_rd_en,
  output logic      [llfifo_geom_pkg::mm_sz-1:0]       mm_addr,
  input  wire logic [llfifo_geom_pkg::num_queues-1:0]  rd_req,
  output logic                                         pv_rd,
  output logic      [llfifo_geom_pkg::qid_sz-1:0]      pv_qid,
  input  wire logic [llfifo_geom_pkg::pid_sz-1:0]      lm_d_out,
  output logic                                         lm_wr_en,
  output logic                                         lm_rd_en,
  output logic      [llfifo_geom_pkg::pid_sz-1:0]      lm_d_in,
  output logic      [llfifo_geom_pkg::pid_sz-1:0]      lm_rd_addr,
  output logic      [llfifo_geom_pkg::pid_sz-1:0]      lm_wr_addr
);

  llfifo_ctl_pkg::desc_t hd [llfifo_geom_pkg::num_queues];  // write side
  llfifo_ctl_pkg::desc_t td [llfifo_geom_pkg::num_queues];  // read side

  llfifo_ctl_pkg::pp_state_t pp_state;

  logic                                    wr_phase;
  logic [llfifo_geom_pkg::pid_sz-1:0]      init_cnt;
  logic [llfifo_geom_pkg::pid_sz-1:0]      free_hptr;
  logic [llfifo_geom_pkg::pid_sz-1:0]      free_tptr;
  logic [llfifo_geom_pkg::fcnt_sz-1:0]     free_cnt;
  logic [llfifo_geom_pkg::num_queues-1:0]  pp_update;  // tail page waits for link
  logic [llfifo_geom_pkg::num_queues-1:0]  not_empty;
  logic [llfifo_geom_pkg::qid_sz-1:0]      last_id;
  logic [llfifo_geom_pkg::qid_sz-1:0]      grant_id;
  logic                                    grant_vld;

  llfifo_ctl_pkg::desc_t wq;  // descriptor of the writing queue
  llfifo_ctl_pkg::desc_t rq;  // descriptor of the granted queue
  logic                  need_page;
  logic                  wr_go;
  logic                  alloc;
  logic                  rd_go;
  logic                  roll;   // read leaves its page

  // --------------------
  // round robin grant
  // --------------------
  always_comb
  begin
    logic [llfifo_geom_pkg::qid_sz-1:0] idx;
    grant_vld = 1'b0;
    grant_id  = last_id;
    for (int i = 0; i < llfifo_geom_pkg::num_queues; i++)
    begin
      not_empty[i] = td[i].valid && ({td[i].page, td[i].wp} != {hd[i].page, hd[i].wp});
    end
    for (int k = 1; k <= llfifo_geom_pkg::num_queues; k++)
    begin
      idx = last_id + llfifo_geom_pkg::qid_sz'(k);
      if (!grant_vld && rd_req[idx] && not_empty[idx])
      begin
        grant_vld = 1'b1;
        grant_id  = idx;
      end
    end
  end

  // --------------------
  // write and read decode
  // --------------------
  assign wq        = hd[c_qid];
  assign rq        = td[grant_id];
  assign need_page = !wq.valid || (wq.wp == llfifo_geom_pkg::wp_sz'(llfifo_geom_pkg::pagesize - 1));
  assign c_drdy    = wr_phase && init_done && (!need_page || (free_cnt != '0));
  assign wr_go     = c_srdy && c_drdy;
  assign alloc     = wr_go && need_page;
  assign rd_go     = !wr_phase && init_done && grant_vld;
  assign roll      = rd_go && (rq.wp == llfifo_geom_pkg::wp_sz'(llfifo_geom_pkg::pagesize - 1));

  assign mm_wr_en = wr_go;
  assign mm_rd_en = rd_go;

  always_comb
  begin
    if (wr_phase)
    begin
      if (wq.valid)
        mm_addr = {wq.page, wq.wp};
      else
        mm_addr = {free_hptr, {llfifo_geom_pkg::wp_sz{1'b0}}};  // first word of new page
    end
    else
    begin
      mm_addr = {rq.page, rq.wp};
    end
  end

  // link memory port sharing
  always_comb
  begin
    lm_wr_en   = 1'b0;
    lm_rd_en   = 1'b0;
    lm_d_in    = '0;
    lm_wr_addr = '0;
    lm_rd_addr = '0;
    if (pp_state == llfifo_ctl_pkg::pp_init)
    begin
      lm_wr_en   = 1'b1;  // chain page n to n+1
      lm_wr_addr = init_cnt;
      lm_d_in    = init_cnt + 1'b1;
    end
    else if (wr_phase)
    begin
      if (alloc)
      begin
        lm_rd_en   = 1'b1;  // fetch next free head
        lm_rd_addr = free_hptr;
      end
      if (alloc && wq.valid)
      begin
        lm_wr_en   = 1'b1;  // link full page to new one
        lm_wr_addr = wq.page;
        lm_d_in    = free_hptr;
      end
    end
    else if (roll)
    begin
      lm_rd_en   = 1'b1;  // where the queue goes next
      lm_rd_addr = rq.page;
      if (free_cnt != '0)
      begin
        lm_wr_en   = 1'b1;  // append old page at free tail
        lm_wr_addr = free_tptr;
        lm_d_in    = rq.page;
      end
    end
  end

  // --------------------
  // state
  // --------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_phase  <= 1'b0;
      pp_state  <= llfifo_ctl_pkg::pp_idle;
      init_cnt  <= '0;
      init_done <= 1'b0;
      free_hptr <= '0;
      free_tptr <= '0;
      free_cnt  <= '0;
      pp_update <= '0;
      last_id   <= '0;
      pv_rd     <= 1'b0;
      pv_qid    <= '0;
      for (int i = 0; i < llfifo_geom_pkg::num_queues; i++)
      begin
        hd[i] <= '0;
        td[i] <= '0;
      end
    end
    else
    begin
      wr_phase <= ~wr_phase;
      pv_rd    <= mm_rd_en;  // lines up with mm_d_out
      if (mm_rd_en)
      begin
        pv_qid  <= grant_id;
        last_id <= grant_id;
      end

      case (pp_state)
        llfifo_ctl_pkg::pp_idle:
        begin
          if (init)
          begin
            pp_state  <= llfifo_ctl_pkg::pp_init;
            init_cnt  <= '0;
            init_done <= 1'b0;
            pp_update <= '0;
            for (int i = 0; i < llfifo_geom_pkg::num_queues; i++)
            begin
              hd[i] <= '0;
              td[i] <= '0;
            end
          end
          else if (alloc)
          begin
            pp_state <= llfifo_ctl_pkg::pp_adv_ptr;
          end
        end
        llfifo_ctl_pkg::pp_init:
        begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt == llfifo_geom_pkg::pid_sz'(llfifo_geom_pkg::num_pages - 1))
          begin
            pp_state  <= llfifo_ctl_pkg::pp_idle;
            init_done <= 1'b1;
            free_hptr <= '0;
            free_tptr <= llfifo_geom_pkg::pid_sz'(llfifo_geom_pkg::num_pages - 1);
            free_cnt  <= llfifo_geom_pkg::fcnt_sz'(llfifo_geom_pkg::num_pages);
          end
        end
        default:
        begin
          pp_state  <= llfifo_ctl_pkg::pp_idle;
          free_hptr <= lm_d_out;  // link of the page just taken
        end
      endcase

      // write side
      if (wr_go)
      begin
        if (need_page)
        begin
          free_cnt <= free_cnt - 1'b1;
          hd[c_qid] <= '{valid: 1'b1, page: free_hptr,
                         wp: {{(llfifo_geom_pkg::wp_sz-1){1'b0}}, !wq.valid}};
          if (!wq.valid)
          begin
            td[c_qid] <= '{valid: 1'b1, page: free_hptr, wp: '0};
          end
        end
        else
        begin
          hd[c_qid].wp <= wq.wp + 1'b1;
        end
      end

      // read side
      if (rd_go)
      begin
        td[grant_id].wp <= rq.wp + 1'b1;  // wraps to 0 on roll
      end
      if (roll)
      begin
        pp_update[grant_id] <= 1'b1;
        free_tptr <= rq.page;
        free_cnt  <= free_cnt + 1'b1;
        if (free_cnt == '0)
        begin
          free_hptr <= rq.page;  // list was empty
        end
      end

      // follow the link fetched in the last read phase
      if (wr_phase)
      begin
        for (int i = 0; i < llfifo_geom_pkg::num_queues; i++)
        begin
          if (pp_update[i])
          begin
            td[i].page   <= lm_d_out;
            pp_update[i] <= 1'b0;
          end
        end
      end
    end
  end

  a_mm_one_port : assert property (
    @(posedge clk) disable iff (reset) !(mm_wr_en && mm_rd_en)
  );

  // pages only move between queues and the free list
  a_free_cnt_max : assert property (
    @(posedge clk) disable iff (reset)
      free_cnt <= llfifo_geom_pkg::fcnt_sz'(llfifo_geom_pkg::num_pages)
  );

endmodule

`default_nettype wire

// File: hdl/llfifo_out_buf.sv
`timescale 1ns/1ps
`default_nettype none

module llfifo_out_buf (
  input  wire logic                                    clk,
  input  wire logic                                    reset,
  input  wire logic [llfifo_geom_pkg::num_queues-1:0]  rd_mask,
  output logic      [llfifo_geom_pkg::num_queues-1:0]  rd_req,
  input  wire logic                                    pv_rd,
  input  wire logic [llfifo_geom_pkg::qid_sz-1:0]      pv_qid,
  input  wire logic [llfifo_geom_pkg::width-1:0]       mm_d_out,
  output logic                                         p_srdy,
  input  wire logic                                    p_drdy,
  output logic      [llfifo_geom_pkg::qid_sz-1:0]      p_qid,
  output logic      [llfifo_geom_pkg::width-1:0]       p_data
);

  logic [llfifo_geom_pkg::qid_sz-1:0]  q_mem [llfifo_ctl_pkg::ob_depth];
  logic [llfifo_geom_pkg::width-1:0]   d_mem [llfifo_ctl_pkg::ob_depth];

  logic [$clog2(llfifo_ctl_pkg::ob_depth)-1:0] wptr;
  logic [$clog2(llfifo_ctl_pkg::ob_depth)-1:0] rptr;
  logic [llfifo_ctl_pkg::ob_cnt_sz-1:0]        count;
  logic [llfifo_ctl_pkg::ob_cnt_sz-1:0]        used;  // entries plus in-flight read
  logic                                        pop;

  // --------------------
  // credit gating
  // --------------------
  assign used   = count + llfifo_ctl_pkg::ob_cnt_sz'(pv_rd);
  assign rd_req = rd_mask & {llfifo_geom_pkg::num_queues{
                    used < llfifo_ctl_pkg::ob_cnt_sz'(llfifo_ctl_pkg::ob_depth)}};

  assign p_srdy = (count != '0);
  assign p_qid  = q_mem[rptr];
  assign p_data = d_mem[rptr];
  assign pop    = p_srdy && p_drdy;

  always_ff @(posedge clk)
  begin
    if (pv_rd)
    begin
      q_mem[wptr] <= pv_qid;
      d_mem[wptr] <= mm_d_out;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else
    begin
      if (pv_rd)
        wptr <= wptr + 1'b1;
      if (pop)
        rptr <= rptr + 1'b1;
      case ({pv_rd, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a read that arrives must always find room
  a_no_overflow : assert property (
    @(posedge clk) disable iff (reset)
      pv_rd |-> (count < llfifo_ctl_pkg::ob_cnt_sz'(llfifo_ctl_pkg::ob_depth))
  );

endmodule

`default_nettype wire

// File: hdl/llfifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module llfifo_top (
  input  wire logic                                    clk,
  input  wire logic                                    reset,
  input  wire logic                                    init,
  output logic                                         init_done,
  input  wire logic                                    c_srdy,
  output logic                                         c_drdy,
  input  wire logic [llfifo_geom_pkg::qid_sz-1:0]      c_qid,
  input  wire logic [llfifo_geom_pkg::width-1:0]       c_data,
  input  wire logic [llfifo_geom_pkg::num_queues-1:0]  rd_mask,
  output logic                                         p_srdy,
  input  wire logic                                    p_drdy,
  output logic      [llfifo_geom_pkg::qid_sz-1:0]      p_qid,
  output logic      [llfifo_geom_pkg::width-1:0]       p_data
);

  logic                                    mm_wr_en;
  logic                                    mm_rd_en;
  logic [llfifo_geom_pkg::mm_sz-1:0]       mm_addr;
  logic [llfifo_geom_pkg::width-1:0]       mm_d_out;
  logic [llfifo_geom_pkg::num_queues-1:0]  rd_req;
  logic                                    pv_rd;
  logic [llfifo_geom_pkg::qid_sz-1:0]      pv_qid;
  logic                                    lm_wr_en;
  logic                                    lm_rd_en;
  logic [llfifo_geom_pkg::pid_sz-1:0]      lm_d_in;
  logic [llfifo_geom_pkg::pid_sz-1:0]      lm_d_out;
  logic [llfifo_geom_pkg::pid_sz-1:0]      lm_rd_addr;
  logic [llfifo_geom_pkg::pid_sz-1:0]      lm_wr_addr;

  llfifo_ctl u_ctl (
    .clk        (clk),
    .reset      (reset),
    .init       (init),
    .init_done  (init_done),
    .c_srdy     (c_srdy),
    .c_drdy     (c_drdy),
    .c_qid      (c_qid),
    .mm_wr_en   (mm_wr_en),
    .mm_rd_en   (mm_rd_en),
    .mm_addr    (mm_addr),
    .rd_req     (rd_req),
    .pv_rd      (pv_rd),
    .pv_qid     (pv_qid),
    .lm_d_out   (lm_d_out),
    .lm_wr_en   (lm_wr_en),
    .lm_rd_en   (lm_rd_en),
    .lm_d_in    (lm_d_in),
    .lm_rd_addr (lm_rd_addr),
    .lm_wr_addr (lm_wr_addr)
  );

  // shared data pages, one port used per phase
  llfifo_ram #(
    .dw    (llfifo_geom_pkg::width),
    .depth (llfifo_geom_pkg::num_pages * llfifo_geom_pkg::pagesize)
  ) u_page_ram (
    .clk     (clk),
    .wr_en   (mm_wr_en),
    .wr_addr (mm_addr),
    .wr_data (c_data),
    .rd_en   (mm_rd_en),
    .rd_addr (mm_addr),
    .rd_data (mm_d_out)
  );

  // next page pointers
  llfifo_ram #(
    .dw    (llfifo_geom_pkg::pid_sz),
    .depth (llfifo_geom_pkg::num_pages)
  ) u_link_ram (
    .clk     (clk),
    .wr_en   (lm_wr_en),
    .wr_addr (lm_wr_addr),
    .wr_data (lm_d_in),
    .rd_en   (lm_rd_en),
    .rd_addr (lm_rd_addr),
    .rd_data (lm_d_out)
  );

  llfifo_out_buf u_out_buf (
    .clk      (clk),
    .reset    (reset),
    .rd_mask  (rd_mask),
    .rd_req   (rd_req),
    .pv_rd    (pv_rd),
    .pv_qid   (pv_qid),
    .mm_d_out (mm_d_out),
    .p_srdy   (p_srdy),
    .p_drdy   (p_drdy),
    .p_qid    (p_qid),
    .p_data   (p_data)
  );

endmodule

`default_nettype wire

// File: tests/tb_llfifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_llfifo;

  localparam int rand_cycles  = 4000;
  localparam int fill_cycles  = 8 * llfifo_geom_pkg::num_pages * llfifo_geom_pkg::pagesize;
  localparam int cycle_limit  = 4 * (rand_cycles + fill_cycles);
  localparam int stall_cycles = 40;  // no write for this long means full
  localparam int drain_limit  = 4 * llfifo_geom_pkg::num_pages * llfifo_geom_pkg::pagesize;
  localparam int model_depth  = 256;

  logic                                    clk;
  logic                                    reset;
  logic                                    init;
  logic                                    init_done;
  logic                                    c_srdy;
  logic                                    c_drdy;
  logic [llfifo_geom_pkg::qid_sz-1:0]      c_qid;
  logic [llfifo_geom_pkg::width-1:0]       c_data;
  logic [llfifo_geom_pkg::num_queues-1:0]  rd_mask;
  logic                                    p_srdy;
  logic                                    p_drdy;
  logic [llfifo_geom_pkg::qid_sz-1:0]      p_qid;
  logic [llfifo_geom_pkg::width-1:0]       p_data;

  // reference model, one ring per queue
  logic [llfifo_geom_pkg::width-1:0] model_mem [llfifo_geom_pkg::num_queues][model_depth];
  logic [7:0]                        model_wr  [llfifo_geom_pkg::num_queues];
  logic [7:0]                        model_rd  [llfifo_geom_pkg::num_queues];

  logic [2:0]                              mask_hist [llfifo_geom_pkg::num_queues];
  logic [llfifo_geom_pkg::num_queues-1:0]  quiet;  // queue may not deliver
  logic                                    hold_prev;
  logic [llfifo_geom_pkg::qid_sz-1:0]      prev_qid;
  logic [llfifo_geom_pkg::width-1:0]       prev_data;

  logic [31:0]               rng;
  int                        wr_count;
  int                        cycle_cnt;
  int                        mismatch_cnt;
  int                        fail_cnt;
  int                        cap_first;
  int                        cap_second;
  logic                      init_ok;
  llfifo_ctl_pkg::pp_state_t seq_state;

  llfifo_top DUT (
    .clk       (clk),
    .reset     (reset),
    .init      (init),
    .init_done (init_done),
    .c_srdy    (c_srdy),
    .c_drdy    (c_drdy),
    .c_qid     (c_qid),
    .c_data    (c_data),
    .rd_mask   (rd_mask),
    .p_srdy    (p_srdy),
    .p_drdy    (p_drdy),
    .p_qid     (p_qid),
    .p_data    (p_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    lcg_step = s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] queue_fill(input int q);
    queue_fill = model_wr[q] - model_rd[q];
  endfunction

  function automatic int model_total();
    int total;
    total = 0;
    for (int i = 0; i < llfifo_geom_pkg::num_queues; i++)
      total = total + int'(queue_fill(i));
    model_total = total;
  endfunction

  task automatic check_data(input string name, input logic [llfifo_geom_pkg::width-1:0] got,
                            input logic [llfifo_geom_pkg::width-1:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %0h, expected %0h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_qid(input string name, input logic [llfifo_geom_pkg::qid_sz-1:0] got,
                           input logic [llfifo_geom_pkg::qid_sz-1:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // --------------------
  // monitor and model
  // --------------------
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (hold_prev)  // stalled word must not move
      begin
        check_bit("p_srdy", p_srdy, 1'b1);
        check_qid("p_qid", p_qid, prev_qid);
        check_data("p_data", p_data, prev_data);
      end
      if (p_srdy && p_drdy)
      begin
        if (quiet[p_qid])
        begin
          $display("at %0t: word delivered on masked queue %0d", $time, p_qid);
          fail_cnt++;
        end
        if (queue_fill(p_qid) == 8'd0)
        begin
          $display("at %0t: word on queue %0d with no word expected", $time, p_qid);
          fail_cnt++;
        end
        else
        begin
          check_data("p_data", p_data, model_mem[p_qid][model_rd[p_qid]]);
          model_rd[p_qid] = model_rd[p_qid] + 8'd1;
        end
      end
      if (c_srdy && c_drdy)
      begin
        model_mem[c_qid][model_wr[c_qid]] = c_data;
        model_wr[c_qid] = model_wr[c_qid] + 8'd1;
        wr_count++;
      end
      hold_prev = p_srdy && !p_drdy;
      prev_qid  = p_qid;
      prev_data = p_data;
      // masked three cycles with an empty buffer, nothing can still arrive
      for (int i = 0; i < llfifo_geom_pkg::num_queues; i++)
      begin
        mask_hist[i] = {mask_hist[i][1:0], rd_mask[i]};
        if (rd_mask[i])
          quiet[i] = 1'b0;
        else if (mask_hist[i] == 3'b000 && !p_srdy)
          quiet[i] = 1'b1;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("run stopped by timeout after %0d cycles", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // --------------------
  // test phases
  // --------------------
  task automatic check_init();
    int n;
    init   = 1'b1;
    c_srdy = 1'b1;
    c_qid  = '0;
    for (n = 0; n <= llfifo_geom_pkg::num_pages + 1; n++)
    begin
      @(negedge clk);
      check_bit("init_done", init_done, n == llfifo_geom_pkg::num_pages + 1);
      if (n <= llfifo_geom_pkg::num_pages)
        check_bit("c_drdy", c_drdy, 1'b0);
      @(posedge clk);
      #2;
      init = 1'b0;
      if (n == llfifo_geom_pkg::num_pages)
        c_srdy = 1'b0;
    end
    n = 0;
    while (!init_done && n < 4 * llfifo_geom_pkg::num_pages)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!init_done)
    begin
      seq_state = DUT.u_ctl.pp_state;
      $display("init_done never rose, link sequencer stuck in %s", seq_state.name());
      fail_cnt++;
      init_ok = 1'b0;
    end
  endtask

  task automatic fill_one_queue(output int accepted);
    int start;
    int last;
    int idle;
    start   = wr_count;
    last    = wr_count;
    idle    = 0;
    rd_mask = '0;
    p_drdy  = 1'b1;
    c_qid   = '0;
    c_srdy  = 1'b1;
    while (idle < stall_cycles)
    begin
      rng    = lcg_step(rng);
      c_data = rng[31:24];
      @(posedge clk);
      #2;
      if (wr_count != last)
      begin
        last = wr_count;
        idle = 0;
      end
      else
        idle++;
    end
    c_srdy   = 1'b0;
    accepted = wr_count - start;
  endtask

  task automatic check_capacity(input string name, input int words);
    if (words > llfifo_geom_pkg::num_pages * llfifo_geom_pkg::pagesize)
    begin
      $display("%s accepted %0d words, more than the memory holds", name, words);
      fail_cnt++;
    end
    if (words < (llfifo_geom_pkg::num_pages - 1) * llfifo_geom_pkg::pagesize)
    begin
      $display("%s stopped after only %0d words", name, words);
      fail_cnt++;
    end
  endtask

  task automatic drain_all();
    int waited;
    c_srdy  = 1'b0;
    rd_mask = '1;
    p_drdy  = 1'b1;
    waited  = 0;
    while (model_total() != 0 && waited < drain_limit)
    begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (model_total() != 0)
    begin
      $display("drain stalled with %0d words still queued", model_total());
      fail_cnt++;
    end
    repeat (8) @(posedge clk);  // late extra words get flagged
    #2;
  endtask

  task automatic run_random(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      rng    = lcg_step(rng);
      c_srdy = (rng[31:30] != 2'b00);
      c_qid  = rng[29:28];
      c_data = rng[27:20];
      p_drdy = rng[19];
      if (rng[18:15] == 4'd0)  // mask changes now and then
      begin
        rng     = lcg_step(rng);
        rd_mask = rng[31:28];
      end
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    reset        = 1'b1;
    init         = 1'b0;
    c_srdy       = 1'b0;
    c_qid        = '0;
    c_data       = '0;
    rd_mask      = '0;
    p_drdy       = 1'b0;
    rng          = 32'h65d4;
    wr_count     = 0;
    cycle_cnt    = 0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    init_ok      = 1'b1;
    hold_prev    = 1'b0;
    prev_qid     = '0;
    prev_data    = '0;
    quiet        = '0;
    for (int i = 0; i < llfifo_geom_pkg::num_queues; i++)
    begin
      model_wr[i]  = 8'd0;
      model_rd[i]  = 8'd0;
      mask_hist[i] = 3'b000;
    end

    repeat (9) @(posedge clk);
    @(negedge clk);
    check_bit("c_drdy", c_drdy, 1'b0);
    check_bit("p_srdy", p_srdy, 1'b0);
    check_bit("init_done", init_done, 1'b0);
    @(posedge clk);
    #2;
    reset = 1'b0;

    check_init();
    if (init_ok)
    begin
      fill_one_queue(cap_first);
      check_capacity("first fill", cap_first);
      drain_all();
      fill_one_queue(cap_second);  // needs pages freed by the drain
      check_capacity("refill", cap_second);
      drain_all();
      run_random(rand_cycles);
      drain_all();
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/llfifo_geom_pkg.sv
hdl/llfifo_ctl_pkg.sv
hdl/llfifo_ram.sv
hdl/llfifo_ctl.sv
hdl/llfifo_out_buf.sv
hdl/llfifo_top.sv
tests/tb_llfifo.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_llfifo -f tb.f -o tb_llfifo

out=$(./obj_dir/tb_llfifo)
echo "$out"
echo "$out" | grep -qx "Test OK"
